//--- src/shade_pkg.sv
package shade_pkg;

	////////////////////////////////////////////////////////////
	// Geometry and colour
	////////////////////////////////////////////////////////////
	localparam int VERTEX_W = 20;
	localparam int SQ_W = 2 * VERTEX_W + 2;                  // Sum of three squares
	localparam int COLOR_W = 10;
	localparam int HALF_COLOR_W = COLOR_W / 2;              // Green split across halves
	localparam logic [COLOR_W-1:0] FULL_COLOR = '1;

	// Triangle loop
	localparam int TRIS_PER_PIXEL = 4;
	localparam int TRI_IDX_W = 2;
	localparam int MODEL_LATENCY = 10;
	localparam int LAT_CNT_W = 4;                            // Also reused for the drain
	localparam int PIPE_STAGES = 3;

	////////////////////////////////////////////////////////////
	// Raster and frame buffer bus
	////////////////////////////////////////////////////////////
	localparam int SCREEN_W = 640;
	localparam int SCREEN_H = 480;
	localparam int COORD_W = 10;
	localparam int WB_ADR_W = 20;
	localparam int WB_DAT_W = 16;
	localparam logic [WB_ADR_W-1:0] PLANE_WORDS = WB_ADR_W'(SCREEN_W * SCREEN_H);

	// FSM encodings
	localparam logic [1:0] SEQ_IDLE = 2'd0;
	localparam logic [1:0] SEQ_WAIT = 2'd1;
	localparam logic [1:0] SEQ_SAMPLE = 2'd2;
	localparam logic [1:0] SEQ_DRAIN = 2'd3;
	localparam logic [1:0] WR_IDLE = 2'd0;
	localparam logic [1:0] WR_HI = 2'd1;
	localparam logic [1:0] WR_GAP = 2'd2;
	localparam logic [1:0] WR_LO = 2'd3;

	// One frame buffer pixel as colour fields or as two bus words
	typedef union packed {
		struct packed {
			logic pad_hi;
			logic [HALF_COLOR_W-1:0] g_hi;
			logic [COLOR_W-1:0] r;
			logic pad_lo;
			logic [HALF_COLOR_W-1:0] g_lo;
			logic [COLOR_W-1:0] b;
		} f;
		struct packed {
			logic [WB_DAT_W-1:0] hi;
			logic [WB_DAT_W-1:0] lo;
		} h;
	} pixel_word_t;

endpackage

//--- src/tri_sequencer.sv
`timescale 1ns/1ns

module tri_sequencer (
	input  logic sys_clk,
	input  logic reset,
	input  logic writer_busy,
	input  logic hit,
	input  logic [shade_pkg::VERTEX_W-1:0] hit_x,
	input  logic [shade_pkg::VERTEX_W-1:0] hit_y,
	input  logic [shade_pkg::VERTEX_W-1:0] hit_z,
	input  logic [shade_pkg::VERTEX_W-1:0] eye_x,
	input  logic [shade_pkg::VERTEX_W-1:0] eye_y,
	input  logic [shade_pkg::VERTEX_W-1:0] eye_z,
	input  logic [shade_pkg::COLOR_W-1:0] hit_r,
	input  logic [shade_pkg::COLOR_W-1:0] hit_g,
	input  logic [shade_pkg::COLOR_W-1:0] hit_b,
	output logic request_tri,
	output logic [shade_pkg::TRI_IDX_W-1:0] tri_index,
	output logic smp_valid,
	output logic smp_hit,
	output logic smp_first,
	output logic [shade_pkg::VERTEX_W-1:0] dx,
	output logic [shade_pkg::VERTEX_W-1:0] dy,
	output logic [shade_pkg::VERTEX_W-1:0] dz,
	output logic [shade_pkg::COLOR_W-1:0] smp_r,
	output logic [shade_pkg::COLOR_W-1:0] smp_g,
	output logic [shade_pkg::COLOR_W-1:0] smp_b,
	output logic pixel_done
);

	logic [1:0] state;
	logic [shade_pkg::LAT_CNT_W-1:0] lat_cnt;
	logic last_tri;
	logic sample_now;

	assign last_tri = (int'(tri_index) == shade_pkg::TRIS_PER_PIXEL - 1);
	assign sample_now = (state == shade_pkg::SEQ_WAIT) &&
		(int'(lat_cnt) == shade_pkg::MODEL_LATENCY - 1);

	////////////////////////////////////////////////////////////
	// Triangle loop FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk)
	begin
		if (reset)
		begin
			state <= shade_pkg::SEQ_IDLE;
			lat_cnt <= '0;
			tri_index <= '0;
			request_tri <= 1'b0;
			smp_valid <= 1'b0;
			pixel_done <= 1'b0;
		end
		else
		begin
			request_tri <= 1'b0;    // All three are single-cycle pulses
			smp_valid <= 1'b0;
			pixel_done <= 1'b0;
			case (state)
				shade_pkg::SEQ_IDLE:
					// Previous pixel must be off to the frame buffer first
					if (!writer_busy && !pixel_done)
					begin
						request_tri <= 1'b1;
						tri_index <= '0;
						lat_cnt <= '0;
						state <= shade_pkg::SEQ_WAIT;
					end
				shade_pkg::SEQ_WAIT:
					if (sample_now)
					begin
						smp_valid <= 1'b1;
						state <= shade_pkg::SEQ_SAMPLE;
					end
					else
						lat_cnt <= lat_cnt + 1'b1;
				shade_pkg::SEQ_SAMPLE:
				begin
					lat_cnt <= '0;
					if (last_tri)
						state <= shade_pkg::SEQ_DRAIN;
					else
					begin
						request_tri <= 1'b1;    // Next triangle right away
						tri_index <= tri_index + 1'b1;
						state <= shade_pkg::SEQ_WAIT;
					end
				end
				shade_pkg::SEQ_DRAIN:
					// Let the distance pipe and the resolver settle
					if (int'(lat_cnt) == shade_pkg::PIPE_STAGES - 1)
					begin
						pixel_done <= 1'b1;
						state <= shade_pkg::SEQ_IDLE;
					end
					else
						lat_cnt <= lat_cnt + 1'b1;
				default:
					state <= shade_pkg::SEQ_IDLE;
			endcase
		end
	end

	// Hit result capture relative to the eye
	always_ff @(posedge sys_clk)
	begin
		if (sample_now)
		begin
			smp_hit <= hit;
			smp_first <= (tri_index == '0);
			dx <= hit_x - eye_x;
			dy <= hit_y - eye_y;
			dz <= hit_z - eye_z;
			smp_r <= hit_r;
			smp_g <= hit_g;
			smp_b <= hit_b;
		end
	end

endmodule

//--- src/eye_distance_pipe.sv
`timescale 1ns/1ns

module eye_distance_pipe (
	input  logic sys_clk,
	input  logic reset,
	input  logic smp_valid,
	input  logic smp_hit,
	input  logic smp_first,
	input  logic [shade_pkg::VERTEX_W-1:0] dx,
	input  logic [shade_pkg::VERTEX_W-1:0] dy,
	input  logic [shade_pkg::VERTEX_W-1:0] dz,
	input  logic [shade_pkg::COLOR_W-1:0] smp_r,
	input  logic [shade_pkg::COLOR_W-1:0] smp_g,
	input  logic [shade_pkg::COLOR_W-1:0] smp_b,
	output logic res_valid,
	output logic res_hit,
	output logic res_first,
	output logic [shade_pkg::SQ_W-1:0] res_dist_sq,
	output logic [shade_pkg::COLOR_W-1:0] res_r,
	output logic [shade_pkg::COLOR_W-1:0] res_g,
	output logic [shade_pkg::COLOR_W-1:0] res_b
);

	logic [shade_pkg::PIPE_STAGES-1:0] valid_q;
	logic [shade_pkg::PIPE_STAGES-1:0] hit_q;
	logic [shade_pkg::PIPE_STAGES-1:0] first_q;
	logic [shade_pkg::COLOR_W-1:0] r_q [shade_pkg::PIPE_STAGES];
	logic [shade_pkg::COLOR_W-1:0] g_q [shade_pkg::PIPE_STAGES];
	logic [shade_pkg::COLOR_W-1:0] b_q [shade_pkg::PIPE_STAGES];
	logic [shade_pkg::SQ_W-1:0] sq_x;
	logic [shade_pkg::SQ_W-1:0] sq_y;
	logic [shade_pkg::SQ_W-1:0] sq_z;
	logic [shade_pkg::SQ_W-1:0] sum_sq;
	logic [shade_pkg::SQ_W-1:0] dist_q;

	// Valid shift register
	always_ff @(posedge sys_clk)
	begin
		if (reset)
			valid_q <= '0;
		else
			valid_q <= {valid_q[shade_pkg::PIPE_STAGES-2:0], smp_valid};
	end

	////////////////////////////////////////////////////////////
	// Square, sum, register
	////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk)
	begin
		// Signed squares of the two's complement differences
		sq_x <= shade_pkg::SQ_W'($signed(dx)) * shade_pkg::SQ_W'($signed(dx));
		sq_y <= shade_pkg::SQ_W'($signed(dy)) * shade_pkg::SQ_W'($signed(dy));
		sq_z <= shade_pkg::SQ_W'($signed(dz)) * shade_pkg::SQ_W'($signed(dz));
		sum_sq <= sq_x + sq_y + sq_z;
		dist_q <= sum_sq;    // Stage three
	end

	// Flags and colour ride along one stage per cycle
	always_ff @(posedge sys_clk)
	begin
		hit_q <= {hit_q[shade_pkg::PIPE_STAGES-2:0], smp_hit};
		first_q <= {first_q[shade_pkg::PIPE_STAGES-2:0], smp_first};
		r_q[0] <= smp_r;
		g_q[0] <= smp_g;
		b_q[0] <= smp_b;
		for (int i = 1; i < shade_pkg::PIPE_STAGES; i++)
		begin
			r_q[i] <= r_q[i-1];
			g_q[i] <= g_q[i-1];
			b_q[i] <= b_q[i-1];
		end
	end

	assign res_valid = valid_q[shade_pkg::PIPE_STAGES-1];
	assign res_hit = hit_q[shade_pkg::PIPE_STAGES-1];
	assign res_first = first_q[shade_pkg::PIPE_STAGES-1];
	assign res_dist_sq = dist_q;
	assign res_r = r_q[shade_pkg::PIPE_STAGES-1];
	assign res_g = g_q[shade_pkg::PIPE_STAGES-1];
	assign res_b = b_q[shade_pkg::PIPE_STAGES-1];

endmodule

//--- src/depth_resolver.sv
`timescale 1ns/1ns

module depth_resolver (
	input  logic sys_clk,
	input  logic reset,
	input  logic accumulate,
	input  logic res_valid,
	input  logic res_hit,
	input  logic res_first,
	input  logic [shade_pkg::SQ_W-1:0] res_dist_sq,
	input  logic [shade_pkg::COLOR_W-1:0] res_r,
	input  logic [shade_pkg::COLOR_W-1:0] res_g,
	input  logic [shade_pkg::COLOR_W-1:0] res_b,
	output logic [shade_pkg::COLOR_W-1:0] pix_r,
	output logic [shade_pkg::COLOR_W-1:0] pix_g,
	output logic [shade_pkg::COLOR_W-1:0] pix_b
);

	logic [shade_pkg::SQ_W-1:0] near_dist;    // Nearest hit so far

	// Channel add that clips at full colour
	function automatic logic [shade_pkg::COLOR_W-1:0] sat_add(
		input logic [shade_pkg::COLOR_W-1:0] a,
		input logic [shade_pkg::COLOR_W-1:0] b
	);
		logic [shade_pkg::COLOR_W:0] sum;

		sum = {1'b0, a} + {1'b0, b};
		if (sum[shade_pkg::COLOR_W])
			return shade_pkg::FULL_COLOR;
		return sum[shade_pkg::COLOR_W-1:0];
	endfunction

	////////////////////////////////////////////////////////////
	// Z resolve per result
	////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk)
	begin
		if (reset)
		begin
			near_dist <= '1;
			pix_r <= '0;
			pix_g <= '0;
			pix_b <= '0;
		end
		else if (res_valid)
		begin
			if (res_first)
			begin
				// First triangle starts the pixel over
				if (res_hit)
				begin
					near_dist <= res_dist_sq;
					pix_r <= res_r;
					pix_g <= res_g;
					pix_b <= res_b;
				end
				else
				begin
					near_dist <= '1;    // Farthest possible for the background
					pix_r <= '0;
					pix_g <= '0;
					pix_b <= '0;
				end
			end
			else if (res_hit)
			begin
				if (accumulate)
				begin
					pix_r <= sat_add(pix_r, res_r);
					pix_g <= sat_add(pix_g, res_g);
					pix_b <= sat_add(pix_b, res_b);
				end
				else if (res_dist_sq <= near_dist)
				begin
					// Later triangle wins a tie
					near_dist <= res_dist_sq;
					pix_r <= res_r;
					pix_g <= res_g;
					pix_b <= res_b;
				end
			end
		end
	end

endmodule

//--- src/pixel_writer.sv
`timescale 1ns/1ns

module pixel_writer (
	input  logic sys_clk,
	input  logic reset,
	input  logic pixel_done,
	input  logic [shade_pkg::COLOR_W-1:0] pix_r,
	input  logic [shade_pkg::COLOR_W-1:0] pix_g,
	input  logic [shade_pkg::COLOR_W-1:0] pix_b,
	input  logic wb_ack,
	output logic writer_busy,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [shade_pkg::WB_ADR_W-1:0] wb_adr,
	output logic [shade_pkg::WB_DAT_W-1:0] wb_dat_o
);

	logic [1:0] state;
	logic [shade_pkg::COORD_W-1:0] x_pos;
	logic [shade_pkg::COORD_W-1:0] y_pos;
	logic [shade_pkg::WB_ADR_W-1:0] pixel_addr;    // Tracks y * SCREEN_W + x
	logic x_wrap;
	logic y_wrap;
	shade_pkg::pixel_word_t pix_word;
	shade_pkg::pixel_word_t word_q;

	assign x_wrap = (int'(x_pos) == shade_pkg::SCREEN_W - 1);
	assign y_wrap = (int'(y_pos) == shade_pkg::SCREEN_H - 1);

	// Pack colour with zero pad bits
	always_comb
	begin
		pix_word = '0;
		pix_word.f.g_hi = pix_g[shade_pkg::COLOR_W-1:shade_pkg::HALF_COLOR_W];
		pix_word.f.r = pix_r;
		pix_word.f.g_lo = pix_g[shade_pkg::HALF_COLOR_W-1:0];
		pix_word.f.b = pix_b;
	end

	////////////////////////////////////////////////////////////
	// Wishbone master, two single writes per pixel
	////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk)
	begin
		if (reset)
		begin
			state <= shade_pkg::WR_IDLE;
			writer_busy <= 1'b0;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
			x_pos <= '0;
			y_pos <= '0;
			pixel_addr <= '0;
		end
		else
		begin
			case (state)
				shade_pkg::WR_IDLE:
					if (pixel_done)
					begin
						writer_busy <= 1'b1;
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= 1'b1;
						state <= shade_pkg::WR_HI;
					end
				shade_pkg::WR_HI:
					if (wb_ack)
					begin
						wb_cyc <= 1'b0;    // Bus idle for one cycle between halves
						wb_stb <= 1'b0;
						wb_we <= 1'b0;
						state <= shade_pkg::WR_GAP;
					end
				shade_pkg::WR_GAP:
				begin
					wb_cyc <= 1'b1;
					wb_stb <= 1'b1;
					wb_we <= 1'b1;
					state <= shade_pkg::WR_LO;
				end
				shade_pkg::WR_LO:
					if (wb_ack)
					begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we <= 1'b0;
						writer_busy <= 1'b0;
						state <= shade_pkg::WR_IDLE;
						// Raster step
						if (x_wrap)
						begin
							x_pos <= '0;
							y_pos <= y_wrap ? '0 : y_pos + 1'b1;
						end
						else
							x_pos <= x_pos + 1'b1;
						pixel_addr <= (x_wrap && y_wrap) ? '0 : pixel_addr + 1'b1;
					end
				default:
					state <= shade_pkg::WR_IDLE;
			endcase
		end
	end

	// Address and data hold steady until ack
	always_ff @(posedge sys_clk)
	begin
		if (state == shade_pkg::WR_IDLE && pixel_done)
		begin
			word_q <= pix_word;
			wb_adr <= pixel_addr;
			wb_dat_o <= pix_word.h.hi;
		end
		else if (state == shade_pkg::WR_GAP)
		begin
			wb_adr <= pixel_addr + shade_pkg::PLANE_WORDS;    // Second plane
			wb_dat_o <= word_q.h.lo;
		end
	end

endmodule

//--- src/pixel_shader_top.sv
`timescale 1ns/1ns

module pixel_shader_top (
	input  logic sys_clk,
	input  logic reset,
	input  logic accumulate,
	input  logic hit,
	input  logic [shade_pkg::VERTEX_W-1:0] hit_x,
	input  logic [shade_pkg::VERTEX_W-1:0] hit_y,
	input  logic [shade_pkg::VERTEX_W-1:0] hit_z,
	input  logic [shade_pkg::VERTEX_W-1:0] eye_x,
	input  logic [shade_pkg::VERTEX_W-1:0] eye_y,
	input  logic [shade_pkg::VERTEX_W-1:0] eye_z,
	input  logic [shade_pkg::COLOR_W-1:0] hit_r,
	input  logic [shade_pkg::COLOR_W-1:0] hit_g,
	input  logic [shade_pkg::COLOR_W-1:0] hit_b,
	input  logic wb_ack,
	output logic request_tri,
	output logic [shade_pkg::TRI_IDX_W-1:0] tri_index,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [shade_pkg::WB_ADR_W-1:0] wb_adr,
	output logic [shade_pkg::WB_DAT_W-1:0] wb_dat_o
);

	// Sample stream
	logic smp_valid, smp_hit, smp_first;
	logic [shade_pkg::VERTEX_W-1:0] dx, dy, dz;
	logic [shade_pkg::COLOR_W-1:0] smp_r, smp_g, smp_b;

	// Resolver input
	logic res_valid, res_hit, res_first;
	logic [shade_pkg::SQ_W-1:0] res_dist_sq;
	logic [shade_pkg::COLOR_W-1:0] res_r, res_g, res_b;

	logic [shade_pkg::COLOR_W-1:0] pix_r, pix_g, pix_b;
	logic pixel_done;
	logic writer_busy;

	tri_sequencer tri_sequencer_i (.*);

	eye_distance_pipe eye_distance_pipe_i (.*);

	depth_resolver depth_resolver_i (.*);

	pixel_writer pixel_writer_i (.*);

endmodule

//--- tests/pixel_shader_tests.svh
////////////////////////////////////////////////////////////
// Triangle table and reference colour
////////////////////////////////////////////////////////////

// Offsets relative to the eye
task automatic set_tri(input int t, input bit h, input int ox, input int oy, input int oz,
		input int r, input int g, input int b);
	tbl_hit[t] = h;
	tbl_x[t] = EYE_X + ox;
	tbl_y[t] = EYE_Y + oy;
	tbl_z[t] = EYE_Z + oz;
	tbl_r[t] = r;
	tbl_g[t] = g;
	tbl_b[t] = b;
endtask

task automatic clear_table();
	for (int t = 0; t < TRIS; t++)
		set_tri(t, 1'b0, 0, 0, 0, 0, 0, 0);
endtask

function automatic int rand_below(input int n);
	return int'($unsigned($random(seed)) % n);
endfunction

task automatic load_random_pixel(input bit accum);
	accumulate = accum;
	for (int t = 0; t < TRIS; t++)
		set_tri(t, ($random(seed) % 2) != 0, rand_below(2001) - 1000,
			rand_below(2001) - 1000, rand_below(2001) - 1000,
			rand_below(1024), rand_below(1024), rand_below(1024));
endtask

function automatic longint dist_sq(input int t);
	longint dx, dy, dz;

	dx = tbl_x[t] - EYE_X;
	dy = tbl_y[t] - EYE_Y;
	dz = tbl_z[t] - EYE_Z;
	return dx * dx + dy * dy + dz * dz;
endfunction

function automatic int sat_channel(input int a, input int b);
	return (a + b > int'(shade_pkg::FULL_COLOR)) ? int'(shade_pkg::FULL_COLOR) : a + b;
endfunction

// Black unless something is hit
task automatic reference_colour(output int r, output int g, output int b);
	longint best;
	bit have_hit;

	r = 0;
	g = 0;
	b = 0;
	best = 0;
	have_hit = 1'b0;
	for (int t = 0; t < TRIS; t++)
	begin
		if (!tbl_hit[t])
			continue;
		if (accumulate)
		begin
			r = sat_channel(r, tbl_r[t]);
			g = sat_channel(g, tbl_g[t]);
			b = sat_channel(b, tbl_b[t]);
		end
		else if (!have_hit || dist_sq(t) <= best)    // Ties go to the later triangle
		begin
			best = dist_sq(t);
			have_hit = 1'b1;
			r = tbl_r[t];
			g = tbl_g[t];
			b = tbl_b[t];
		end
	end
endtask

////////////////////////////////////////////////////////////
// Pixel check and tests
////////////////////////////////////////////////////////////
task automatic finish_pixel();
	int r, g, b;
	int base;
	int first;
	logic [15:0] want_hi;
	logic [15:0] want_lo;

	reference_colour(r, g, b);
	want_hi = {1'b0, 5'(g >> 5), 10'(r)};    // Green split over both halves
	want_lo = {1'b0, 5'(g), 10'(b)};
	base = pix_y * shade_pkg::SCREEN_W + pix_x;
	first = 2 * pixel_num;
	while (write_count < first + 2)
		@(negedge sys_clk);
	check_value("wb_adr hi", 32'(wr_adr[first]), 32'(base));
	check_value("wb_dat_o hi", 32'(wr_dat[first]), 32'(want_hi));
	check_value("wb_adr lo", 32'(wr_adr[first + 1]),
		32'(base + shade_pkg::SCREEN_W * shade_pkg::SCREEN_H));
	check_value("wb_dat_o lo", 32'(wr_dat[first + 1]), 32'(want_lo));
	check_value("wb_we", 32'({wr_we[first], wr_we[first + 1]}), 32'd3);
	pixel_num++;
	pix_x++;
	if (pix_x == shade_pkg::SCREEN_W)
	begin
		pix_x = 0;
		pix_y = (pix_y + 1) % shade_pkg::SCREEN_H;
	end
endtask

task automatic test_reset_state();
	int start;

	start = error_count;
	check_value("request_tri", 32'(request_tri), 32'd0);
	check_value("wb_cyc", 32'(wb_cyc), 32'd0);
	check_value("wb_stb", 32'(wb_stb), 32'd0);
	reset = 1'b0;
	finish_pixel();    // Empty table, black at address 0
	report_test("reset state", start);
endtask

task automatic test_nearest();
	int start;

	start = error_count;
	accumulate = 1'b0;
	set_tri(0, 1'b1, 100, 0, 0, 100, 200, 300);
	set_tri(1, 1'b1, -50, 0, 0, 400, 500, 600);
	set_tri(2, 1'b1, 0, -20, 10, 11, 22, 33);
	set_tri(3, 1'b1, 0, 0, 300, 900, 900, 900);
	finish_pixel();
	set_tri(0, 1'b0, 0, 0, 0, 5, 5, 5);
	set_tri(1, 1'b1, 30, 0, -40, 1, 2, 3);
	set_tri(2, 1'b1, 500, 0, 0, 7, 7, 7);
	set_tri(3, 1'b1, -40, 30, 0, 1023, 0, 512);    // Same distance as triangle 1
	finish_pixel();
	set_tri(0, 1'b1, 1, 0, 0, 300, 301, 302);
	set_tri(1, 1'b1, 0, 2, 0, 10, 10, 10);
	set_tri(2, 1'b1, 0, 0, -3, 20, 20, 20);
	set_tri(3, 1'b0, 0, 0, 0, 30, 30, 30);
	finish_pixel();
	report_test("nearest hit", start);
endtask

task automatic test_accumulate();
	int start;

	start = error_count;
	accumulate = 1'b1;
	set_tri(0, 1'b1, 9, 9, 9, 100, 200, 300);
	set_tri(1, 1'b0, 0, 0, 0, 50, 50, 50);
	set_tri(2, 1'b1, -9, 0, 0, 10, 20, 30);
	set_tri(3, 1'b1, 0, 400, 0, 1, 2, 3);
	finish_pixel();
	// Red and blue run past full colour
	set_tri(0, 1'b1, 5, 0, 0, 700, 100, 1000);
	set_tri(1, 1'b1, 6, 0, 0, 400, 100, 23);
	set_tri(2, 1'b1, 7, 0, 0, 0, 100, 0);
	set_tri(3, 1'b1, 8, 0, 0, 0, 0, 1);
	finish_pixel();
	report_test("accumulate", start);
endtask

task automatic test_no_hit();
	int start;

	start = error_count;
	for (int m = 0; m < 2; m++)
	begin
		accumulate = (m == 1);
		for (int t = 0; t < TRIS; t++)
			set_tri(t, 1'b0, 10 * t, 0, 0, 1000, 1000, 1000);
		finish_pixel();
	end
	report_test("no hit", start);
endtask

task automatic test_packing();
	int start;

	start = error_count;
	for (int p = 0; p < 4; p++)
	begin
		load_random_pixel(p % 2 == 1);
		finish_pixel();
	end
	report_test("packing and addresses", start);
endtask

task automatic test_back_pressure();
	int start;

	start = error_count;
	load_random_pixel(1'b0);
	finish_pixel();
	load_random_pixel(1'b1);
	finish_pixel();
	assert (long_acks > 0)
	else
	begin
		$display("No acknowledge was delayed, so bus hold was never exercised");
		error_count++;
	end
	report_test("back-pressure", start);
endtask

//--- tests/pixel_shader_tb.sv
`timescale 1ns/1ns

module pixel_shader_tb;

	localparam int VW = shade_pkg::VERTEX_W;
	localparam int CW = shade_pkg::COLOR_W;
	localparam int TRIS = shade_pkg::TRIS_PER_PIXEL;
	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_PIXELS = 14;    // Sum over all tests
	localparam int PIXEL_CYCLES = TRIS * (shade_pkg::MODEL_LATENCY + 2) + 20;
	localparam int WATCHDOG_NS = (NUM_PIXELS * PIXEL_CYCLES + RESET_CYCLES) * CLK_PERIOD;
	localparam int EYE_X = 5000;
	localparam int EYE_Y = 6000;
	localparam int EYE_Z = 7000;

	logic sys_clk;
	logic reset;
	logic accumulate;
	logic hit;
	logic [VW-1:0] hit_x, hit_y, hit_z;
	logic [VW-1:0] eye_x, eye_y, eye_z;
	logic [CW-1:0] hit_r, hit_g, hit_b;
	logic wb_ack;
	logic request_tri;
	logic [shade_pkg::TRI_IDX_W-1:0] tri_index;
	logic wb_cyc, wb_stb, wb_we;
	logic [shade_pkg::WB_ADR_W-1:0] wb_adr;
	logic [shade_pkg::WB_DAT_W-1:0] wb_dat_o;

	// Triangle table of the pixel in progress, absolute coordinates
	bit tbl_hit [TRIS];
	int tbl_x [TRIS];
	int tbl_y [TRIS];
	int tbl_z [TRIS];
	int tbl_r [TRIS];
	int tbl_g [TRIS];
	int tbl_b [TRIS];

	// Frame buffer writes in arrival order
	logic [shade_pkg::WB_ADR_W-1:0] wr_adr [$];
	logic [shade_pkg::WB_DAT_W-1:0] wr_dat [$];
	logic wr_we [$];
	int write_count = 0;
	int long_acks = 0;    // Acks held back at least one cycle
	logic pixel_open = 1'b0;

	int seed = 32'hc2e2a186;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int pixel_num = 0;
	int pix_x = 0;
	int pix_y = 0;

	pixel_shader_top pixel_shader_top_i (.*);

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		assert (got === want)
		else
		begin
			$display("Error at %0t: %s is 'h%0h, expected 'h%0h", $time, name, got, want);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before)
			$display("%s: ok", name);
		else
		begin
			tests_failed++;
			$display("%s: %0d errors", name, error_count - errors_before);
		end
	endtask

	`include "pixel_shader_tests.svh"

	initial
	begin
		sys_clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	////////////////////////////////////////////////////////////
	// Bus and sequencer rules, checked every cycle
	////////////////////////////////////////////////////////////
	assert property (@(posedge sys_clk) reset |=> (!wb_cyc && !wb_stb && !request_tri))
	else
	begin
		$display("%0t: wb_cyc, wb_stb or request_tri not low after reset", $time);
		error_count++;
	end

	assert property (@(posedge sys_clk) disable iff (reset)
		(wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat_o)))
	else
	begin
		$display("%0t: write request changed or dropped before wb_ack", $time);
		error_count++;
	end

	// Next pixel may only start once both halves are acknowledged
	assert property (@(posedge sys_clk) disable iff (reset) pixel_open |-> !request_tri)
	else
	begin
		$display("%0t: request_tri issued while a pixel write was still open", $time);
		error_count++;
	end

	// Intersection model drives each result for the sampling edge only
	initial
	begin : hit_model
		int idx;

		hit = 1'b0;
		{hit_x, hit_y, hit_z} = '0;
		{hit_r, hit_g, hit_b} = '0;
		forever
		begin
			@(negedge sys_clk);
			if (request_tri)
			begin
				idx = int'(tri_index);
				repeat (shade_pkg::MODEL_LATENCY - 1)
					@(negedge sys_clk);
				hit = tbl_hit[idx];
				hit_x = VW'(tbl_x[idx]);
				hit_y = VW'(tbl_y[idx]);
				hit_z = VW'(tbl_z[idx]);
				hit_r = CW'(tbl_r[idx]);
				hit_g = CW'(tbl_g[idx]);
				hit_b = CW'(tbl_b[idx]);
				@(negedge sys_clk);
				hit = 1'b0;    // Valid for one edge only
				{hit_x, hit_y, hit_z} = '0;
				{hit_r, hit_g, hit_b} = '0;
			end
		end
	end

	// Frame buffer slave
	initial
	begin : wishbone_slave
		int delay;

		wb_ack = 1'b0;
		forever
		begin
			@(negedge sys_clk);
			if (wb_cyc && wb_stb)
			begin
				if (write_count % 2 == 0)
					pixel_open = 1'b1;    // Hi half opens the pixel
				delay = $unsigned($random(seed)) % 4;
				if (delay > 0)
					long_acks++;
				repeat (delay)
					@(negedge sys_clk);
				wr_adr.push_back(wb_adr);
				wr_dat.push_back(wb_dat_o);
				wr_we.push_back(wb_we);
				if (write_count % 2 == 1)
					pixel_open = 1'b0;
				write_count++;
				wb_ack = 1'b1;
				@(negedge sys_clk);
				wb_ack = 1'b0;
			end
		end
	end

	initial
	begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout: not all pixels reached the frame buffer in time");
		$display("Test failed");
		$finish;
	end

	initial
	begin : main
		reset = 1'b1;
		accumulate = 1'b0;
		eye_x = VW'(EYE_X);
		eye_y = VW'(EYE_Y);
		eye_z = VW'(EYE_Z);
		clear_table();    // First pixel starts right after reset
		repeat (RESET_CYCLES)
			@(negedge sys_clk);
		test_reset_state();
		test_nearest();
		test_accumulate();
		test_no_hit();
		test_packing();
		test_back_pressure();
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- build.f
+incdir+tests
src/shade_pkg.sv
src/tri_sequencer.sv
src/eye_distance_pipe.sv
src/depth_resolver.sv
src/pixel_writer.sv
src/pixel_shader_top.sv
tests/pixel_shader_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module pixel_shader_tb &&
./obj_dir/Vpixel_shader_tb | tee /dev/stderr | grep -x "Test passed" > /dev/null &&
echo "run_sim: simulation ok" ||
{
	echo "run_sim: simulation FAILED"
	exit 1
}
